// ==== Bender.yml ====
package:
  name: cart_loader

sources:
  - cart_pkg.sv
  - load_beat_if.sv
  - header_info_if.sv
  - load_capture.sv
  - header_scan.sv
  - region_select.sv
  - rom_write_pacer.sv
  - cart_loader.sv
  - target: simulation
    files:
      - cart_loader_tb.sv

// ==== cart_loader.sv ====
// Cartridge load path top
`default_nettype none
`timescale 1ns/100ps

module cart_loader (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	input  logic                             download,
	input  logic                             wr,
	input  logic [cart_pkg::addr_w-1:0]      addr,
	input  logic [cart_pkg::data_w-1:0]      data,
	input  logic [cart_pkg::index_w-1:0]     index,
	input  logic                             region_auto,
	input  logic                             region_disable,
	input  cart_pkg::prio_t                  region_prio,
	input  logic                             rom_wrack,
	output logic                             rom_wr,
	output logic [cart_pkg::addr_w-1:0]      rom_wraddr,
	output logic [cart_pkg::data_w-1:0]      rom_din,
	output logic                             ioctl_wait,
	output logic [cart_pkg::addr_w-1:0]      rom_size,
	output cart_pkg::region_t                region_req,
	output logic                             region_set,
	output logic [cart_pkg::quirk_count-1:0] quirks
);

	load_beat_if   beat_bus ();
	header_info_if info_bus ();

	load_capture load_capture_inst (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.download (download),
		.wr       (wr),
		.addr     (addr),
		.data     (data),
		.beat     (beat_bus.src)
	);

	//////////////////////////////////////////////////
	// Header path

	header_scan header_scan_inst (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.beat    (beat_bus.dst),
		.info    (info_bus.src),
		.quirks  (quirks)
	);

	region_select region_select_inst (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.region_auto    (region_auto),
		.region_disable (region_disable),
		.region_prio    (region_prio),
		.index          (index),
		.info           (info_bus.dst),
		.region_req     (region_req),
		.region_set     (region_set)
	);

	//////////////////////////////////////////////////
	// ROM write path

	rom_write_pacer rom_write_pacer_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rom_wrack  (rom_wrack),
		.beat       (beat_bus.dst),
		.rom_wr     (rom_wr),
		.rom_wraddr (rom_wraddr),
		.rom_din    (rom_din),
		.ioctl_wait (ioctl_wait),
		.rom_size   (rom_size)
	);

endmodule

`default_nettype wire

// ==== cart_loader_tb.sv ====
// Cartridge loader testbench
`default_nettype none
`timescale 1ns/100ps

module cart_loader_tb;

	typedef struct packed {
		logic [7:0]  r0;
		logic [7:0]  r1;
		logic [7:0]  r2;
		logic [63:0] code;
		logic        auto_en;
		logic        no_region;
		logic [1:0]  prio;
		logic [7:0]  index;
		logic [1:0]  exp_req;
		logic        exp_set;
		logic [7:0]  exp_quirks;
	} row_t;

	localparam int row_count   = 26;
	localparam int word_count  = 66;
	localparam int cycle_limit = row_count * word_count * 12 + 500;

	// Region bytes r0 r1 at 0x1F0, r2 at 0x1F2, then code, auto, disable, prio, index,
	// expected region_req, region_set and quirks
	localparam row_t rows [row_count] = '{
		'{"J", "U", "E", "T-081276", 1'b1, 1'b0, 2'd0, 8'h00, 2'd1, 1'b1, 8'h01},
		'{"J", "U", "E", "T-81406 ", 1'b1, 1'b0, 2'd1, 8'h00, 2'd2, 1'b1, 8'h01},
		'{"J", "U", "E", "T-081586", 1'b1, 1'b0, 2'd2, 8'h00, 2'd1, 1'b1, 8'h01},
		'{"J", "U", "E", "T-81576 ", 1'b1, 1'b0, 2'd3, 8'h00, 2'd0, 1'b1, 8'h01},
		'{"J", " ", " ", "T-81476 ", 1'b1, 1'b0, 2'd0, 8'h00, 2'd0, 1'b1, 8'h01},
		'{"J", " ", " ", "MK-1215 ", 1'b1, 1'b0, 2'd1, 8'h00, 2'd0, 1'b1, 8'h02},
		// No letters, so the first region of the order
		'{" ", " ", " ", "G-4060  ", 1'b1, 1'b0, 2'd0, 8'h00, 2'd1, 1'b1, 8'h02},
		'{" ", " ", " ", "00001211", 1'b1, 1'b0, 2'd1, 8'h00, 2'd2, 1'b1, 8'h02},
		'{" ", " ", " ", "MK-1228 ", 1'b1, 1'b0, 2'd2, 8'h00, 2'd1, 1'b1, 8'h02},
		'{" ", " ", " ", "G-5538  ", 1'b1, 1'b0, 2'd3, 8'h00, 2'd0, 1'b1, 8'h02},
		'{"J", "E", " ", "00004076", 1'b1, 1'b0, 2'd0, 8'h00, 2'd2, 1'b1, 8'h02},
		'{"J", "E", " ", "T-12046 ", 1'b1, 1'b0, 2'd2, 8'h00, 2'd0, 1'b1, 8'h02},
		'{"U", "E", " ", "T-12053 ", 1'b1, 1'b0, 2'd1, 8'h00, 2'd2, 1'b1, 8'h02},
		'{"U", "E", " ", "G-4524  ", 1'b1, 1'b0, 2'd3, 8'h00, 2'd1, 1'b1, 8'h02},
		'{" ", " ", "E", "T-113016", 1'b1, 1'b0, 2'd0, 8'h00, 2'd2, 1'b1, 8'h08},
		'{" ", " ", "U", "T-89016 ", 1'b1, 1'b0, 2'd3, 8'h00, 2'd1, 1'b1, 8'h04},
		'{"J", "U", " ", "T-574023", 1'b1, 1'b0, 2'd1, 8'h00, 2'd1, 1'b1, 8'h10},
		'{"4", " ", " ", "T-574013", 1'b1, 1'b0, 2'd2, 8'h00, 2'd2, 1'b1, 8'h10},
		// Region from the load index
		'{"J", "U", "E", "TITAN002", 1'b0, 1'b0, 2'd0, 8'h80, 2'd2, 1'b1, 8'h20},
		'{"J", "U", "E", "MK-1229 ", 1'b0, 1'b0, 2'd0, 8'h41, 2'd1, 1'b1, 8'h40},
		'{"J", "U", "E", "G-7001  ", 1'b0, 1'b0, 2'd0, 8'h00, 2'd0, 1'b0, 8'h40},
		'{"J", "U", "E", "T-35036 ", 1'b0, 1'b0, 2'd0, 8'h3F, 2'd0, 1'b1, 8'h80},
		'{"J", "U", "E", "T-25073 ", 1'b1, 1'b1, 2'd0, 8'h00, 2'd0, 1'b0, 8'h80},
		'{" ", " ", " ", "MK-1137-", 1'b0, 1'b1, 2'd0, 8'h80, 2'd0, 1'b0, 8'h80},
		'{"U", " ", " ", "T-99999 ", 1'b1, 1'b0, 2'd0, 8'h00, 2'd1, 1'b1, 8'h00},
		'{"J", "U", "E", "MK-1137 ", 1'b1, 1'b0, 2'd2, 8'h00, 2'd1, 1'b1, 8'h00}
	};

	logic                             clk_sys;
	logic                             rst_n;
	logic                             download;
	logic                             wr;
	logic [cart_pkg::addr_w-1:0]      addr;
	logic [cart_pkg::data_w-1:0]      data;
	logic [cart_pkg::index_w-1:0]     index;
	logic                             region_auto;
	logic                             region_disable;
	cart_pkg::prio_t                  region_prio;
	logic                             rom_wrack;
	logic                             rom_wr;
	logic [cart_pkg::addr_w-1:0]      rom_wraddr;
	logic [cart_pkg::data_w-1:0]      rom_din;
	logic                             ioctl_wait;
	logic [cart_pkg::addr_w-1:0]      rom_size;
	cart_pkg::region_t                region_req;
	logic                             region_set;
	logic [cart_pkg::quirk_count-1:0] quirks;

	logic        exp_wr;
	logic        last_wr;
	logic        set_seen;
	logic [31:0] lfsr;
	logic [2:0]  delay;
	int          toggles;
	int          cycles;
	int          checks;
	int          errors;
	int          row_errs;

	cart_loader cart_loader_inst (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.download       (download),
		.wr             (wr),
		.addr           (addr),
		.data           (data),
		.index          (index),
		.region_auto    (region_auto),
		.region_disable (region_disable),
		.region_prio    (region_prio),
		.rom_wrack      (rom_wrack),
		.rom_wr         (rom_wr),
		.rom_wraddr     (rom_wraddr),
		.rom_din        (rom_din),
		.ioctl_wait     (ioctl_wait),
		.rom_size       (rom_size),
		.region_req     (region_req),
		.region_set     (region_set),
		.quirks         (quirks)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Header image word, byte at the even address in the low half
	function automatic logic [15:0] header_word(input logic [24:0] a, input row_t r);
		logic [7:0] lo;
		logic [7:0] hi;
		{hi, lo} = a[15:0] ^ 16'hA55A ^ {7'd0, a[24:16]};
		// Product code occupies bytes 0x183 to 0x18A
		for (int k = 0; k < 8; k++) begin
			if (25'h183 + k == a) begin
				lo = r.code[63 - 8*k -: 8];
			end
			if (25'h183 + k == a + 25'd1) begin
				hi = r.code[63 - 8*k -: 8];
			end
		end
		if (a == 25'h1F0) begin
			lo = r.r0;
			hi = r.r1;
		end
		if (a == 25'h1F2) begin
			lo = r.r2;
			hi = "J";
		end
		return {hi, lo};
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
			errors++;
			row_errs++;
		end
	endtask

	//////////////////////////////////////////////////
	// Loader and memory models

	// Called on a falling edge, returns on the falling edge after the wait drops
	task automatic write_word(input logic [24:0] a, input logic [15:0] d);
		wr     = 1'b1;
		addr   = a;
		data   = d;
		exp_wr = ~exp_wr;
		@(negedge clk_sys);
		wr = 1'b0;
		@(negedge clk_sys);
		// Two cycles after the write the request is out and the loader is held
		check_value(ioctl_wait, 1'b1, "ioctl_wait raised");
		check_value(rom_wr, exp_wr, "rom_wr toggle");
		check_value(rom_wraddr, a, "rom_wraddr");
		check_value(rom_din, {d[7:0], d[15:8]}, "rom_din");
		while (ioctl_wait) @(negedge clk_sys);
	endtask

	// Acknowledge after 0 to 7 cycles
	initial begin
		rom_wrack = 1'b0;
		lfsr      = 32'h8c9b;
		delay     = 3'd0;
		forever begin
			@(negedge clk_sys);
			if (rst_n && rom_wr !== rom_wrack) begin
				for (int k = 0; k < 3; k++) begin
					delay = {delay[1:0], lfsr[0]};
					lfsr  = lfsr_next(lfsr);
				end
				repeat (delay) @(negedge clk_sys);
				rom_wrack = rom_wr;
			end
		end
	end

	// Toggle count and region_set watch, sampled on the rising edge
	initial begin
		toggles  = 0;
		last_wr  = 1'b0;
		set_seen = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (rst_n) begin
				if (rom_wr !== last_wr) begin
					toggles++;
				end
				last_wr = rom_wr;
				if (download && region_set) begin
					set_seen = 1'b1;
				end
			end
		end
	end

	task automatic load_row(input int i);
		row_t        r;
		logic [24:0] a;
		int          start_toggles;
		r              = rows[i];
		row_errs       = 0;
		region_auto    = r.auto_en;
		region_disable = r.no_region;
		region_prio    = cart_pkg::prio_t'(r.prio);
		index          = r.index;
		set_seen       = 1'b0;
		start_toggles  = toggles;
		download       = 1'b1;
		@(negedge clk_sys);
		for (a = 25'h180; a <= 25'h202; a = a + 25'd2) begin
			write_word(a, header_word(a, r));
		end
		check_value(quirks, r.exp_quirks, "quirks");
		if (!r.no_region) begin
			check_value(region_req, r.exp_req, "region_req");
		end
		check_value(region_set, r.exp_set, "region_set");
		if (r.no_region) begin
			check_value(set_seen, 1'b0, "region_set during disabled load");
		end
		download = 1'b0;
		repeat (6) @(negedge clk_sys);
		check_value(region_set, 1'b0, "region_set after download");
		check_value(rom_size, 25'h202, "rom_size");
		check_value(rom_wraddr, 25'h202, "rom_wraddr after download");
		check_value(toggles - start_toggles, word_count, "rom_wr toggle count");
		$display("Row %0d  code %s  %0d mismatches", i, r.code, row_errs);
	endtask

	//////////////////////////////////////////////////
	// Run control

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk_sys);
			cycles++;
			if (cycles >= cycle_limit) begin
				$display("Timeout: run did not finish within %0d cycles", cycle_limit);
				$display("Simulation failed");
				$finish;
			end
		end
	end

	initial begin
		checks         = 0;
		errors         = 0;
		row_errs       = 0;
		rst_n          = 1'b0;
		download       = 1'b0;
		wr             = 1'b0;
		addr           = '0;
		data           = '0;
		index          = '0;
		region_auto    = 1'b0;
		region_disable = 1'b0;
		region_prio    = cart_pkg::prio_us_eu_jp;
		exp_wr         = 1'b0;
		repeat (16) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		// Everything idle out of reset
		check_value(rom_wr, 1'b0, "rom_wr after reset");
		check_value(ioctl_wait, 1'b0, "ioctl_wait after reset");
		check_value(region_set, 1'b0, "region_set after reset");
		check_value(quirks, 8'h00, "quirks after reset");
		for (int i = 0; i < row_count; i++) begin
			load_row(i);
		end
		$display("%0d rows, %0d checks, %0d errors", row_count, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== cart_pkg.sv ====
// Cartridge loader definitions
`default_nettype none

package cart_pkg;

	//////////////////////////////////////////////////
	// Widths

	localparam int addr_w  = 25;
	localparam int data_w  = 16;
	localparam int index_w = 8;

	//////////////////////////////////////////////////
	// Header word addresses

	localparam logic [addr_w-1:0] hdr_id_first_addr = 25'h182;
	localparam logic [addr_w-1:0] hdr_id_last_addr  = 25'h18A;
	localparam logic [addr_w-1:0] hdr_id_check_addr = 25'h18C;
	localparam logic [addr_w-1:0] hdr_region_addr_a = 25'h1F0;
	localparam logic [addr_w-1:0] hdr_region_addr_b = 25'h1F2;
	localparam logic [addr_w-1:0] hdr_end_addr      = 25'h200;

	typedef enum logic [1:0] {
		region_jp = 2'd0,
		region_us = 2'd1,
		region_eu = 2'd2
	} region_t;

	// Auto region search order, first entry is also the fallback
	typedef enum logic [1:0] {
		prio_us_eu_jp = 2'd0,
		prio_eu_us_jp = 2'd1,
		prio_us_jp_eu = 2'd2,
		prio_jp_us_eu = 2'd3
	} prio_t;

	//////////////////////////////////////////////////
	// Compatibility quirks

	localparam int quirk_count = 8;

	typedef enum logic [2:0] {
		quirk_sram,
		quirk_eeprom,
		quirk_fifo,
		quirk_noram,
		quirk_pier,
		quirk_ttn2,
		quirk_svp,
		quirk_fmbusy
	} quirk_t;

	// Eight ASCII characters, first character in the top byte
	typedef logic [63:0] cart_id_t;

	typedef struct packed {
		cart_id_t id;
		quirk_t   quirk;
	} quirk_entry_t;

	localparam quirk_entry_t quirk_table [24] = '{
		'{"T-081276", quirk_sram},
		'{"T-81406 ", quirk_sram},
		'{"T-081586", quirk_sram},
		'{"T-81576 ", quirk_sram},
		'{"T-81476 ", quirk_sram},
		// Serial EEPROM saves
		'{"MK-1215 ", quirk_eeprom},
		'{"G-4060  ", quirk_eeprom},
		'{"00001211", quirk_eeprom},
		'{"MK-1228 ", quirk_eeprom},
		'{"G-5538  ", quirk_eeprom},
		'{"00004076", quirk_eeprom},
		'{"T-12046 ", quirk_eeprom},
		'{"T-12053 ", quirk_eeprom},
		'{"G-4524  ", quirk_eeprom},
		'{"T-113016", quirk_noram},
		'{"T-89016 ", quirk_fifo},
		'{"T-574023", quirk_pier},
		'{"T-574013", quirk_pier},
		'{"TITAN002", quirk_ttn2},
		// DSP carts, three regional codes for the FM busy case
		'{"MK-1229 ", quirk_svp},
		'{"G-7001  ", quirk_svp},
		'{"T-35036 ", quirk_fmbusy},
		'{"T-25073 ", quirk_fmbusy},
		'{"MK-1137-", quirk_fmbusy}
	};

	// First matching entry wins, unknown codes give zero
	function automatic logic [quirk_count-1:0] quirk_lookup(input cart_id_t id);
		logic [quirk_count-1:0] hit;
		hit = '0;
		foreach (quirk_table[i]) begin
			if (hit == '0 && quirk_table[i].id == id) begin
				hit[quirk_table[i].quirk] = 1'b1;
			end
		end
		return hit;
	endfunction

endpackage

`default_nettype wire

// ==== header_info_if.sv ====
// Cartridge header info bus
`default_nettype none
`timescale 1ns/100ps

interface header_info_if;

	// High from the end of the header until download ends
	logic hdr_ready;

	// Region letters seen in the header
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;

	modport src (
		output hdr_ready,
		output hdr_j, hdr_u, hdr_e
	);

	modport dst (
		input hdr_ready,
		input hdr_j, hdr_u, hdr_e
	);

endinterface

`default_nettype wire

// ==== header_scan.sv ====
// Cartridge header scanner
`default_nettype none
`timescale 1ns/100ps

module header_scan (
	input  logic                             clk_sys,
	input  logic                             rst_n,
	load_beat_if.dst                         beat,
	header_info_if.src                       info,
	output logic [cart_pkg::quirk_count-1:0] quirks
);

	cart_pkg::cart_id_t cart_id;
	logic [2:0]         region_flags;
	logic [2:0]         lo_flags;
	logic [2:0]         hi_flags;
	logic [2:0]         hit_flags;
	logic               at_region_a;
	logic               at_region_b;

	// Region letter class as {e, u, j}
	function automatic logic [2:0] classify(input logic [7:0] ch);
		logic [2:0] f;
		f = 3'b000;
		if (ch == "J") begin
			f[0] = 1'b1;
		end else if (ch == "U") begin
			f[1] = 1'b1;
		end else if (ch >= "0" && ch <= "Z") begin
			f[2] = 1'b1;
		end
		return f;
	endfunction

	//////////////////////////////////////////////////
	// Region field

	assign at_region_a = beat.beat_addr == cart_pkg::hdr_region_addr_a;
	assign at_region_b = beat.beat_addr == cart_pkg::hdr_region_addr_b;
	assign lo_flags    = classify(beat.beat_data[7:0]);
	assign hi_flags    = classify(beat.beat_data[15:8]);

	// Both bytes of the first word, low byte only of the second
	assign hit_flags = at_region_a ? (lo_flags | hi_flags) :
	                   at_region_b ? lo_flags : 3'b000;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			region_flags   <= 3'b000;
			info.hdr_ready <= 1'b0;
		end else begin
			if (beat.dl_start) begin
				region_flags <= 3'b000;
			end else if (beat.beat_valid) begin
				region_flags <= region_flags | hit_flags;
			end

			if (beat.dl_end) begin
				info.hdr_ready <= 1'b0;
			end else if (beat.beat_valid && beat.beat_addr == cart_pkg::hdr_end_addr) begin
				info.hdr_ready <= 1'b1;
			end
		end
	end

	assign info.hdr_j = region_flags[0];
	assign info.hdr_u = region_flags[1];
	assign info.hdr_e = region_flags[2];

	//////////////////////////////////////////////////
	// Product code and quirks

	// Words arrive byte swapped, the code starts in the high byte of the first word
	always_ff @(posedge clk_sys) begin
		if (beat.beat_valid) begin
			case (beat.beat_addr)
				cart_pkg::hdr_id_first_addr:
					cart_id[63:56] <= beat.beat_data[15:8];
				cart_pkg::hdr_id_first_addr + 25'd2:
					cart_id[55:40] <= {beat.beat_data[7:0], beat.beat_data[15:8]};
				cart_pkg::hdr_id_first_addr + 25'd4:
					cart_id[39:24] <= {beat.beat_data[7:0], beat.beat_data[15:8]};
				cart_pkg::hdr_id_first_addr + 25'd6:
					cart_id[23:8] <= {beat.beat_data[7:0], beat.beat_data[15:8]};
				cart_pkg::hdr_id_last_addr:
					cart_id[7:0] <= beat.beat_data[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			quirks <= '0;
		end else if (beat.dl_start) begin
			quirks <= '0;
		end else if (beat.beat_valid && beat.beat_addr == cart_pkg::hdr_id_check_addr) begin
			quirks <= cart_pkg::quirk_lookup(cart_id);
		end
	end

	a_single_quirk: assert property (
		@(posedge clk_sys) disable iff (!rst_n) $onehot0(quirks)
	) else $error("More than one quirk flag set");

endmodule

`default_nettype wire

// ==== load_beat_if.sv ====
// Loader beat bus
`default_nettype none
`timescale 1ns/100ps

interface load_beat_if;

	// One captured loader write
	logic                        beat_valid;
	logic [cart_pkg::addr_w-1:0] beat_addr;
	logic [cart_pkg::data_w-1:0] beat_data;

	// Download framing
	logic dl_start;
	logic dl_end;
	logic dl_active;

	modport src (
		output beat_valid, beat_addr, beat_data,
		output dl_start, dl_end, dl_active
	);

	modport dst (
		input beat_valid, beat_addr, beat_data,
		input dl_start, dl_end, dl_active
	);

endinterface

`default_nettype wire

// ==== load_capture.sv ====
// Loader write capture
`default_nettype none
`timescale 1ns/100ps

module load_capture (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        download,
	input  logic                        wr,
	input  logic [cart_pkg::addr_w-1:0] addr,
	input  logic [cart_pkg::data_w-1:0] data,
	load_beat_if.src                    beat
);

	// Strobes and framing, dl_active doubles as the previous download level
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			beat.beat_valid <= 1'b0;
			beat.dl_active  <= 1'b0;
			beat.dl_start   <= 1'b0;
			beat.dl_end     <= 1'b0;
		end else begin
			beat.beat_valid <= wr & download;
			beat.dl_active  <= download;
			beat.dl_start   <= download & ~beat.dl_active;
			beat.dl_end     <= ~download & beat.dl_active;
		end
	end

	// Address stays put after the last write so the image size can be taken from it
	always_ff @(posedge clk_sys) begin
		if (wr && download) begin
			beat.beat_addr <= addr;
			beat.beat_data <= data;
		end
	end

endmodule

`default_nettype wire

// ==== region_select.sv ====
// Console region selection
`default_nettype none
`timescale 1ns/100ps

module region_select (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  logic                         region_auto,
	input  logic                         region_disable,
	input  cart_pkg::prio_t              region_prio,
	input  logic [cart_pkg::index_w-1:0] index,
	header_info_if.dst                   info,
	output cart_pkg::region_t            region_req,
	output logic                         region_set
);

	logic              ready_q;
	logic              ready_rise;
	logic              ready_fall;
	cart_pkg::region_t auto_region;

	// Seen flags are indexed by region code
	function automatic cart_pkg::region_t pick_region(
		input cart_pkg::prio_t prio,
		input logic [2:0]      seen
	);
		cart_pkg::region_t order [3];
		cart_pkg::region_t pick;
		case (prio)
			cart_pkg::prio_us_eu_jp:
				order = '{cart_pkg::region_us, cart_pkg::region_eu, cart_pkg::region_jp};
			cart_pkg::prio_eu_us_jp:
				order = '{cart_pkg::region_eu, cart_pkg::region_us, cart_pkg::region_jp};
			cart_pkg::prio_us_jp_eu:
				order = '{cart_pkg::region_us, cart_pkg::region_jp, cart_pkg::region_eu};
			default:
				order = '{cart_pkg::region_jp, cart_pkg::region_us, cart_pkg::region_eu};
		endcase
		// Walk backwards so the earliest hit wins, no hit leaves the first entry
		pick = order[0];
		for (int i = 2; i >= 0; i--) begin
			if (seen[order[i]]) begin
				pick = order[i];
			end
		end
		return pick;
	endfunction

	assign ready_rise  = info.hdr_ready & ~ready_q;
	assign ready_fall  = ~info.hdr_ready & ready_q;
	assign auto_region = pick_region(region_prio, {info.hdr_e, info.hdr_u, info.hdr_j});

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ready_q    <= 1'b0;
			region_set <= 1'b0;
			region_req <= cart_pkg::region_jp;
		end else begin
			ready_q <= info.hdr_ready;
			if (ready_rise && !region_disable) begin
				if (region_auto) begin
					region_set <= 1'b1;
					region_req <= auto_region;
				end else begin
					// Region comes from the load index top bits
					region_set <= |index;
					region_req <= cart_pkg::region_t'(index[cart_pkg::index_w-1 -: 2]);
				end
			end else if (ready_fall) begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rom_write_pacer.sv ====
// ROM write pacer
`default_nettype none
`timescale 1ns/100ps

module rom_write_pacer (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        rom_wrack,
	load_beat_if.dst                    beat,
	output logic                        rom_wr,
	output logic [cart_pkg::addr_w-1:0] rom_wraddr,
	output logic [cart_pkg::data_w-1:0] rom_din,
	output logic                        ioctl_wait,
	output logic [cart_pkg::addr_w-1:0] rom_size
);

	logic [cart_pkg::addr_w-1:0] wr_addr;

	// Toggle request, memory answers by copying rom_wr onto rom_wrack
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else if (beat.beat_valid) begin
			rom_wr     <= ~rom_wr;
			ioctl_wait <= 1'b1;
		end else if (ioctl_wait && rom_wrack == rom_wr) begin
			ioctl_wait <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (beat.beat_valid) begin
			wr_addr <= beat.beat_addr;
			rom_din <= {beat.beat_data[7:0], beat.beat_data[15:8]};
		end
	end

	// Image size is the address of the final write
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rom_size <= '0;
		end else if (beat.dl_end) begin
			rom_size <= beat.beat_addr;
		end
	end

	assign rom_wraddr = beat.dl_active ? wr_addr : rom_size;

	// Loader must hold off while a write is still in flight
	a_no_overrun: assert property (
		@(posedge clk_sys) disable iff (!rst_n) beat.beat_valid |-> !ioctl_wait
	) else $error("Loader write arrived while ROM write outstanding");

endmodule

`default_nettype wire

// ==== sim.f ====
cart_pkg.sv
load_beat_if.sv
header_info_if.sv
load_capture.sv
header_scan.sv
region_select.sv
rom_write_pacer.sv
cart_loader.sv
cart_loader_tb.sv
